//--- hudPkg.sv
`default_nettype none

package hudPkg;

	// bus widths
	localparam int scoreWidth = 17;
	localparam int addrWidth = 18;
	localparam int coordWidth = 10;

	// five decimal places cover the display range
	localparam int numDigits = 5;

	// glyph geometry in pixels
	localparam int numWidth = 18;
	localparam int numHeight = 21;
	localparam int hiWidth = 38;

	// overlay placement on screen
	localparam int scoreRowY = 20;
	localparam int hiLocX = 340;
	localparam int digitLocX0 = 380;
	localparam int digitPitch = 20;

	// sprite memory layout
	// digits 0 to 9 sit back to back, one glyph per stride
	localparam logic [addrWidth-1:0] numBase0 = 18'd168215;
	localparam logic [addrWidth-1:0] numStride = addrWidth'(numWidth * numHeight);
	localparam logic [addrWidth-1:0] hiBase = 18'd84217;

	// high score sampling
	localparam int frameDivide = 10;
	localparam logic [scoreWidth-1:0] scoreLimit = 17'd100000;

	// glyph under the current pixel
	// digit positions run most significant first
	typedef enum logic [2:0]
	{
		glyphNone = 3'b000,
		glyphDigit1 = 3'b001,
		glyphDigit2 = 3'b010,
		glyphDigit3 = 3'b011,
		glyphDigit4 = 3'b100,
		glyphDigit5 = 3'b101,
		glyphHi = 3'b110
	} glyphSel;

endpackage

`default_nettype wire

//--- glyphIf.sv
`default_nettype none

interface glyphIf import hudPkg::*; ();

	// which glyph the pixel falls in
	glyphSel sel;

	// pixel offset from the glyph's top left corner
	logic [coordWidth-1:0] distX;
	logic [4:0] distY;

	// row length of the selected glyph in sprite memory
	logic [5:0] glyphW;

	// locator side drives the decode
	modport locator
	(
		output sel,
		output distX,
		output distY,
		output glyphW
	);

	// address side only reads
	modport reader
	(
		input sel,
		input distX,
		input distY,
		input glyphW
	);

endinterface

`default_nettype wire

//--- hiScoreControl.sv
`default_nettype none

module hiScoreControl import hudPkg::*;
(
	input  logic frame_Clk,
	input  logic Reset,
	input  logic [scoreWidth-1:0] score,
	output logic [scoreWidth-1:0] hiScore
);

	// frame position within the sample period from 1 to frameDivide
	logic [3:0] frameCount;
	logic sampleNow;

	assign sampleNow = (frameCount == 4'(frameDivide));

	always_ff @(posedge frame_Clk or posedge Reset)
	begin
		if (Reset)
			frameCount <= 4'd1;
		else if (sampleNow)
			frameCount <= 4'd1;
		else
			frameCount <= frameCount + 4'd1;
	end

	// sample, compare and clear once per period
	always_ff @(posedge frame_Clk or posedge Reset)
	begin
		if (Reset)
			hiScore <= '0;
		else if (sampleNow)
		begin
			// start over from zero at the limit
			if (hiScore == scoreLimit)
				hiScore <= '0;
			else if (score > hiScore)
				hiScore <= score;
		end
	end

	frameCountRange: assert property
	(
		@(posedge frame_Clk) disable iff (Reset)
		(frameCount >= 4'd1) && (frameCount <= 4'(frameDivide))
	)
	else
		$error("frame counter outside 1 to %0d", frameDivide);

endmodule

`default_nettype wire

//--- digitConverter.sv
`default_nettype none

module digitConverter import hudPkg::*;
(
	input  logic frame_Clk,
	input  logic Reset,
	input  logic [scoreWidth-1:0] hiScore,
	output logic [3:0] digits [numDigits]
);

	logic [3:0] digitNext [numDigits];

	// decimal split with index 0 as the ten-thousands place
	// a held value at the limit wraps and shows as 00000
	always_comb
	begin
		digitNext[0] = 4'((hiScore / 10000) % 10);
		digitNext[1] = 4'((hiScore / 1000) % 10);
		digitNext[2] = 4'((hiScore / 100) % 10);
		digitNext[3] = 4'((hiScore / 10) % 10);
		digitNext[4] = 4'(hiScore % 10);
	end

	// one edge behind the held score
	always_ff @(posedge frame_Clk or posedge Reset)
	begin
		if (Reset)
		begin
			for (int i = 0; i < numDigits; i++)
				digits[i] <= 4'd0;
		end
		else
		begin
			for (int i = 0; i < numDigits; i++)
				digits[i] <= digitNext[i];
		end
	end

	// every place must index a real digit glyph
	generate
		for (genvar g = 0; g < numDigits; g++)
		begin : gDigitCheck
			digitRange: assert property
			(
				@(posedge frame_Clk) disable iff (Reset)
				digits[g] <= 4'd9
			)
			else
				$error("digit %0d out of range: %0d", g, digits[g]);
		end
	endgenerate

endmodule

`default_nettype wire

//--- glyphLocator.sv
`default_nettype none

module glyphLocator import hudPkg::*;
(
	input  logic [coordWidth-1:0] writeX,
	input  logic [coordWidth-1:0] writeY,
	glyphIf.locator glyph
);

	logic inRow;
	logic [coordWidth-1:0] rowTop;

	assign rowTop = coordWidth'(scoreRowY);

	// all glyphs share one row band
	assign inRow = (writeY >= rowTop) && (writeY < rowTop + coordWidth'(numHeight));

	always_comb
	begin
		logic found;
		logic [coordWidth-1:0] left;

		found = 1'b0;
		left = '0;
		glyph.sel = glyphNone;
		glyph.distX = '0;
		glyph.distY = '0;
		glyph.glyphW = '0;

		if (inRow)
		begin
			// digit columns first, leftmost hit wins
			for (int i = 0; i < numDigits; i++)
			begin
				left = coordWidth'(digitLocX0 + i * digitPitch);
				if (!found && (writeX >= left) && (writeX < left + coordWidth'(numWidth)))
				begin
					found = 1'b1;
					glyph.sel = glyphSel'(i + 1);
					glyph.distX = writeX - left;
					glyph.glyphW = 6'(numWidth);
				end
			end

			// then the label
			left = coordWidth'(hiLocX);
			if (!found && (writeX >= left) && (writeX < left + coordWidth'(hiWidth)))
			begin
				found = 1'b1;
				glyph.sel = glyphHi;
				glyph.distX = writeX - left;
				glyph.glyphW = 6'(hiWidth);
			end

			// row offset only counts inside a glyph
			if (found)
				glyph.distY = 5'(writeY - rowTop);
		end
	end

endmodule

`default_nettype wire

//--- spriteAddressGen.sv
`default_nettype none

module spriteAddressGen import hudPkg::*;
(
	glyphIf.reader glyph,
	input  logic [3:0] digits [numDigits],
	output logic [addrWidth-1:0] address
);

	logic [3:0] digitVal;
	logic [addrWidth-1:0] base;
	logic [addrWidth-1:0] offset;

	// pick the digit shown at this position
	always_comb
	begin
		case (glyph.sel)
			glyphDigit1: digitVal = digits[0];
			glyphDigit2: digitVal = digits[1];
			glyphDigit3: digitVal = digits[2];
			glyphDigit4: digitVal = digits[3];
			glyphDigit5: digitVal = digits[4];
			default: digitVal = 4'd0;
		endcase
	end

	// start of the glyph in sprite memory
	always_comb
	begin
		case (glyph.sel)
			glyphDigit1, glyphDigit2, glyphDigit3, glyphDigit4, glyphDigit5:
				base = numBase0 + addrWidth'(digitVal) * numStride;
			glyphHi:
				base = hiBase;
			default:
				base = '0;
		endcase
	end

	// row major within the glyph
	assign offset = addrWidth'(glyph.distY) * addrWidth'(glyph.glyphW)
		+ addrWidth'(glyph.distX);

	assign address = base + offset;

	// locator must keep the column inside the glyph it reports
	always_comb
	begin
		if (glyph.sel != glyphNone)
		begin
			columnInGlyph: assert final (glyph.distX < coordWidth'(glyph.glyphW))
			else
				$error("distX %0d not below glyph width %0d", glyph.distX, glyph.glyphW);
		end
	end

endmodule

`default_nettype wire

//--- hudOverlay.sv
`default_nettype none

module hudOverlay import hudPkg::*;
(
	input  logic frame_Clk,
	input  logic Reset,
	input  logic [scoreWidth-1:0] score,
	input  logic [coordWidth-1:0] writeX,
	input  logic [coordWidth-1:0] writeY,
	output glyphSel hudOn,
	output logic [addrWidth-1:0] address
);

	logic [scoreWidth-1:0] hiScore;
	logic [3:0] digits [numDigits];

	// decoded glyph and offsets for the current pixel
	glyphIf glyph ();

	hiScoreControl hiScoreCtrl
	(
		.frame_Clk (frame_Clk),
		.Reset     (Reset),
		.score     (score),
		.hiScore   (hiScore)
	);

	digitConverter digitConv
	(
		.frame_Clk (frame_Clk),
		.Reset     (Reset),
		.hiScore   (hiScore),
		.digits    (digits)
	);

	// pixel path, no clock involved
	glyphLocator locator
	(
		.writeX (writeX),
		.writeY (writeY),
		.glyph  (glyph.locator)
	);

	spriteAddressGen addrGen
	(
		.glyph   (glyph.reader),
		.digits  (digits),
		.address (address)
	);

	assign hudOn = glyph.sel;

endmodule

`default_nettype wire

//--- tb_hudOverlay.sv
`default_nettype none

module tb_hudOverlay import hudPkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	// six hex words per vector line
	localparam int fieldsPerVector = 6;
	localparam int maxVectors = 64;
	localparam int memWords = fieldsPerVector * maxVectors;
	localparam logic [31:0] endMarker = 32'hffff_ffff;

	// field positions within one vector
	localparam int fScore = 0;
	localparam int fHold = 1;
	localparam int fWriteX = 2;
	localparam int fWriteY = 3;
	localparam int fHudOn = 4;
	localparam int fAddress = 5;

	// cycles allowed on top of the summed hold counts
	localparam int timeoutSlack = 50;

	logic frame_Clk;
	logic Reset;
	logic [scoreWidth-1:0] score;
	logic [coordWidth-1:0] writeX;
	logic [coordWidth-1:0] writeY;
	glyphSel hudOn;
	logic [addrWidth-1:0] address;

	logic [31:0] vectorMem [memWords];
	int vectorCount;
	int holdSum;
	int cycleLimit;
	int cycleCount;
	int currentVector;

	hudOverlay UUT
	(
		.frame_Clk (frame_Clk),
		.Reset     (Reset),
		.score     (score),
		.writeX    (writeX),
		.writeY    (writeY),
		.hudOn     (hudOn),
		.address   (address)
	);

	// 10 ns period
	always #5 frame_Clk = ~frame_Clk;

	// run length guard counting edges after reset release
	always @(posedge frame_Clk)
	begin
		if (!Reset && (cycleLimit > 0))
		begin
			cycleCount++;
			if (cycleCount > cycleLimit)
			begin
				$display("timeout: the run went past %0d clock cycles without finishing",
					cycleLimit);
				stopRun();
			end
		end
	end

	task automatic stopRun();
		$display("Errors found");
		$fatal(1, "simulation stopped after a failure");
	endtask

	task automatic checkValue
	(
		input string name,
		input logic [31:0] actual,
		input logic [31:0] expected
	);
		if (actual !== expected)
		begin
			$display("[FAIL] %s: got 0x%h, expected 0x%h (vector %0d, time %0t)",
				name, actual, expected, currentVector, $time);
			stopRun();
		end
	endtask

	// reads the vector file and sizes the timeout from its hold counts
	task automatic loadVectors();
		int base;
		int badVector;

		$readmemh("hudInput.txt", vectorMem);
		vectorCount = 0;
		holdSum = 0;
		base = 0;
		badVector = -1;

		// stop at the end marker or at the first unread word
		while ((vectorCount < maxVectors) && !$isunknown(vectorMem[base])
			&& (vectorMem[base] != endMarker))
		begin
			for (int f = 0; f < fieldsPerVector; f++)
			begin
				if ($isunknown(vectorMem[base + f]) && (badVector < 0))
					badVector = vectorCount;
			end
			holdSum += int'(vectorMem[base + fHold]);
			vectorCount++;
			base += fieldsPerVector;
		end

		if (vectorCount == 0)
		begin
			$display("no test vectors could be read from hudInput.txt");
			stopRun();
		end
		else if (badVector >= 0)
		begin
			$display("vector %0d in hudInput.txt is missing one or more fields", badVector);
			stopRun();
		end
		else
		begin
			cycleLimit = holdSum + timeoutSlack;
			$display("loaded %0d vectors, cycle limit %0d", vectorCount, cycleLimit);
		end
	endtask

	task automatic driveVector(input int index);
		int base;

		base = index * fieldsPerVector;
		score = scoreWidth'(vectorMem[base + fScore]);
		writeX = coordWidth'(vectorMem[base + fWriteX]);
		writeY = coordWidth'(vectorMem[base + fWriteY]);
	endtask

	task automatic checkVector(input int index);
		int base;

		base = index * fieldsPerVector;
		checkValue("hudOn", 32'(hudOn), vectorMem[base + fHudOn]);
		checkValue("address", 32'(address), vectorMem[base + fAddress]);
	endtask

	initial
	begin
		int holdCycles;

		frame_Clk = 1'b0;
		Reset = 1'b1;
		score = '0;
		writeX = '0;
		writeY = '0;
		vectorCount = 0;
		holdSum = 0;
		cycleLimit = 0;
		cycleCount = 0;
		currentVector = 0;

		loadVectors();

		// reset spans three rising edges
		repeat (3) @(posedge frame_Clk);
		#1;
		Reset = 1'b0;

		for (int v = 0; v < vectorCount; v++)
		begin
			// first vector goes out together with the reset release
			if (v > 0)
			begin
				@(posedge frame_Clk);
				#1;
			end
			currentVector = v;
			driveVector(v);

			// hold count is the number of edges before the check
			holdCycles = int'(vectorMem[v * fieldsPerVector + fHold]);
			repeat (holdCycles) @(posedge frame_Clk);

			// combinational pixel path settles by mid cycle
			@(negedge frame_Clk);
			checkVector(v);
		end

		$display("ran %0d vectors in %0d cycles", vectorCount, cycleCount);
		$display("No errors");
		$finish;
	end

endmodule

`default_nettype wire

//--- hudInput.txt
// columns: score  hold  writeX  writeY  hudOn  address, all hex
// hold is the number of rising edges that pass before the outputs are checked
// score 0 after reset, digits all zero
0      0  1d1  17   5  29152
0      0  64   64   0  00000
0      0  18e  19   0  00000
0      0  181  29   0  00000
0      0  181  13   0  00000
0      0  17c  14   1  29117
// hi label corners and the gap to digit one
0      0  154  14   6  148f9
0      0  179  28   6  14c16
0      0  17a  1e   0  00000
// score 12345, long enough for one sample edge and the digit register
3039   c  17c  14   1  29291
3039   0  18d  28   1  2940a
3039   0  190  14   2  2940b
3039   0  1a1  28   2  29584
3039   0  1a4  14   3  29585
3039   0  1b5  28   3  296fe
3039   0  1b8  14   4  296ff
3039   0  1c9  28   4  29878
3039   0  1cc  14   5  29879
3039   0  1dd  28   5  299f2
3039   0  1bd  1e   4  297b8
3039   0  15e  19   6  149c1
// lower score 5000 leaves 12345 on display
1388   f  17c  14   1  29291
1388   0  1cc  14   5  29879
1388   0  1a4  14   3  29585
// higher score 67890 replaces it
10932  c  17c  14   1  299f3
10932  0  190  14   2  29b6d
10932  0  1a4  14   3  29ce7
10932  0  1b8  14   4  29e61
10932  0  1dd  28   5  29290
10932  0  1c1  21   4  29f54
10932  0  155  15   6  14920
// limit reached, every place shows zero
186a0  c  1cc  14   5  29117
186a0  0  17c  14   1  29117
// next sample clears the held value, 250 is taken on the one after
fa     8  1b8  14   4  29117
fa     c  1b8  14   4  29879
fa     0  1a4  14   3  2940b
fa     0  1cc  14   5  29117
fa     0  17c  14   1  29117
fa     0  179  14   6  1491e
fa     0  154  28   6  14bf1
// edges of the overlay and one inner pixel of digit five
fa     0  1de  1e   0  00000
fa     0  153  1e   0  00000
fa     0  1d6  23   5  2922f
// end marker
ffffffff 0 0 0 0 0

//--- flist.f
hudPkg.sv
glyphIf.sv
hiScoreControl.sv
digitConverter.sv
glyphLocator.sv
spriteAddressGen.sv
hudOverlay.sv
tb_hudOverlay.sv
